// ==== src/c4_cfg.svh ====
`ifndef C4_CFG_SVH
`define C4_CFG_SVH

// Board geometry
`define C4_COLS 7
`define C4_ROWS 7
`define C4_WIN_LEN 4

// Screen placement on the 160x120 frame buffer
`define C4_ORIGIN_X 8   // Left edge of column 0
`define C4_PITCH_X 22
`define C4_ORIGIN_Y 5   // Top edge of row 0
`define C4_PITCH_Y 16
`define C4_PIECE_SIZE 6

// Player colours in 3-bit RGB
`define C4_COLOUR_P1 3'd4
`define C4_COLOUR_P2 3'd1

// Keyboard scan codes
`define C4_KEY_Z 8'h1A
`define C4_KEY_X 8'h22
`define C4_KEY_C 8'h21
`define C4_KEY_V 8'h2A
`define C4_KEY_B 8'h32
`define C4_KEY_N 8'h31
`define C4_KEY_M 8'h3A
`define C4_KEY_SPACE 8'h29

`endif

// ==== src/c4_pkg.sv ====
`default_nettype none

`include "c4_cfg.svh"

package c4_pkg;

	// Cell content, whose turn it is, and the winner
	typedef enum logic [1:0] {
		PLAYER_NONE = 2'd0,
		PLAYER_ONE  = 2'd1,
		PLAYER_TWO  = 2'd2
	} player_t;

	// Board indices with row 0 at the top
	typedef logic [2:0] col_t;
	typedef logic [2:0] row_t;

	typedef logic [2:0] height_t;   // Holds 0 to 7 pieces in a column

	typedef player_t board_t [`C4_ROWS][`C4_COLS];
	typedef height_t heights_t [`C4_COLS];

	// Frame buffer side
	typedef logic [7:0] pix_x_t;
	typedef logic [6:0] pix_y_t;
	typedef logic [2:0] colour_t;

	typedef logic [7:0] scan_code_t;

endpackage

`default_nettype wire

// ==== src/c4_draw_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Piece draw request from referee to plotter
interface c4_draw_if import c4_pkg::*; ();

	logic req;        // One-cycle pulse only while busy is low
	pix_x_t org_x;
	pix_y_t org_y;
	colour_t colour;
	logic busy;       // High from req until the last pixel

	modport requester (output req, output org_x, output org_y, output colour, input busy);
	modport plotter (input req, input org_x, input org_y, input colour, output busy);

endinterface

`default_nettype wire

// ==== src/c4_key_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_key_decoder import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic key_valid,
	input  logic key_make,
	input  scan_code_t key_code,
	output col_t sel_col,
	output logic drop_pulse
);

	logic press;

	assign press = key_valid && key_make;   // Releases are ignored

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sel_col <= '0;
			drop_pulse <= 1'b0;
		end else begin
			drop_pulse <= press && (key_code == `C4_KEY_SPACE);
			if (press) begin
				case (key_code)
					`C4_KEY_Z: sel_col <= col_t'(0);
					`C4_KEY_X: sel_col <= col_t'(1);
					`C4_KEY_C: sel_col <= col_t'(2);
					`C4_KEY_V: sel_col <= col_t'(3);
					`C4_KEY_B: sel_col <= col_t'(4);
					`C4_KEY_N: sel_col <= col_t'(5);
					`C4_KEY_M: sel_col <= col_t'(6);
					default:   sel_col <= sel_col;   // Keep the last column
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/c4_board_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_board_regs import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic write_en,
	input  col_t write_col,
	input  row_t write_row,
	input  player_t write_player,
	output board_t board,
	output heights_t heights
);

	////////////////////////////////////////////////////////////////////////////
	// Cell storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int r = 0; r < `C4_ROWS; r++) begin
				for (int c = 0; c < `C4_COLS; c++) begin
					board[r][c] <= PLAYER_NONE;
				end
			end
		end else if (write_en) begin
			board[write_row][write_col] <= write_player;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Column fill heights
	////////////////////////////////////////////////////////////////////////////

	// One count per column bumped with every write into it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int c = 0; c < `C4_COLS; c++) begin
				heights[c] <= '0;
			end
		end else if (write_en) begin
			heights[write_col] <= heights[write_col] + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/c4_referee.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_referee import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  col_t sel_col,
	input  logic drop_pulse,
	input  heights_t heights,
	input  player_t winner,
	output logic write_en,
	output col_t write_col,
	output row_t write_row,
	output player_t write_player,
	c4_draw_if.requester draw,
	output player_t turn
);

	height_t col_height;
	row_t land_row;
	logic col_full;
	logic accept;

	////////////////////////////////////////////////////////////////////////////
	// Drop legality
	////////////////////////////////////////////////////////////////////////////

	assign col_height = heights[sel_col];
	assign col_full = (col_height >= height_t'(`C4_ROWS));
	assign land_row = row_t'(`C4_ROWS - 1 - col_height);   // Stack from the bottom row up

	// Plotter idle, no winner yet and room left in the column.
	// A req still in flight counts as busy since the plotter has not seen it
	assign accept = drop_pulse && !draw.busy && !draw.req &&
		(winner == PLAYER_NONE) && !col_full;

	// Board write happens on the accepting edge
	assign write_en = accept;
	assign write_col = sel_col;
	assign write_row = land_row;
	assign write_player = turn;

	////////////////////////////////////////////////////////////////////////////
	// Turn and draw request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			turn <= PLAYER_ONE;
			draw.req <= 1'b0;
		end else begin
			draw.req <= accept;   // One-cycle pulse
			if (accept) begin
				turn <= (turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
			end
		end
	end

	// Screen origin of the landing cell
	always_ff @(posedge clk) begin
		if (accept) begin
			draw.org_x <= pix_x_t'(`C4_ORIGIN_X + `C4_PITCH_X * sel_col);
			draw.org_y <= pix_y_t'(`C4_ORIGIN_Y + `C4_PITCH_Y * land_row);
			draw.colour <= (turn == PLAYER_ONE) ? `C4_COLOUR_P1 : `C4_COLOUR_P2;
		end
	end

endmodule

`default_nettype wire

// ==== src/c4_win_check.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_win_check import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  board_t board,
	output player_t winner
);

	player_t found;

	// Owner of the line starting at (r0, c0) in direction (dr, dc)
	// or PLAYER_NONE when it leaves the board or is mixed
	function automatic player_t line_owner(input board_t b, input int r0, input int c0,
		input int dr, input int dc);
		player_t first;
		logic same;
		int r_end;
		int c_end;
		first = b[r0][c0];
		same = (first != PLAYER_NONE);
		r_end = r0 + dr * (`C4_WIN_LEN - 1);
		c_end = c0 + dc * (`C4_WIN_LEN - 1);
		if (r_end < 0 || r_end >= `C4_ROWS || c_end < 0 || c_end >= `C4_COLS) begin
			same = 1'b0;
		end else begin
			for (int k = 1; k < `C4_WIN_LEN; k++) begin
				if (b[r0 + dr * k][c0 + dc * k] != first)
					same = 1'b0;
			end
		end
		return same ? first : PLAYER_NONE;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Window scan over every start cell
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		found = PLAYER_NONE;
		for (int r = 0; r < `C4_ROWS; r++) begin
			for (int c = 0; c < `C4_COLS; c++) begin
				if (found == PLAYER_NONE) found = line_owner(board, r, c, 0, 1);    // Row
				if (found == PLAYER_NONE) found = line_owner(board, r, c, 1, 0);    // Column
				if (found == PLAYER_NONE) found = line_owner(board, r, c, 1, 1);    // Down right
				if (found == PLAYER_NONE) found = line_owner(board, r, c, -1, 1);   // Up right
			end
		end
	end

	// First winner sticks until reset
	always_ff @(posedge clk) begin
		if (!reset_n)
			winner <= PLAYER_NONE;
		else if (winner == PLAYER_NONE)
			winner <= found;
	end

endmodule

`default_nettype wire

// ==== src/c4_piece_plotter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_piece_plotter import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	c4_draw_if.plotter draw,
	output logic plot,
	output pix_x_t plot_x,
	output pix_y_t plot_y,
	output colour_t plot_colour
);

	localparam logic [2:0] LAST_OFF = 3'(`C4_PIECE_SIZE - 1);

	logic active;
	logic [2:0] off_x;
	logic [2:0] off_y;
	pix_x_t base_x;
	pix_y_t base_y;
	colour_t colour_q;

	////////////////////////////////////////////////////////////////////////////
	// Raster walk with the x offset fastest
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active <= 1'b0;
			off_x <= '0;
			off_y <= '0;
		end else if (!active) begin
			if (draw.req) begin
				active <= 1'b1;
				off_x <= '0;
				off_y <= '0;
			end
		end else if (off_x == LAST_OFF) begin
			off_x <= '0;
			if (off_y == LAST_OFF) begin
				off_y <= '0;
				active <= 1'b0;   // 36th pixel out
			end else begin
				off_y <= off_y + 1'b1;
			end
		end else begin
			off_x <= off_x + 1'b1;
		end
	end

	// Origin and colour held for the whole block
	always_ff @(posedge clk) begin
		if (draw.req && !active) begin
			base_x <= draw.org_x;
			base_y <= draw.org_y;
			colour_q <= draw.colour;
		end
	end

	assign draw.busy = active;
	assign plot = active;
	assign plot_x = base_x + pix_x_t'(off_x);
	assign plot_y = base_y + pix_y_t'(off_y);
	assign plot_colour = colour_q;

endmodule

`default_nettype wire

// ==== src/c4_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module c4_top import c4_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic key_valid,
	input  logic key_make,
	input  scan_code_t key_code,
	output logic plot,
	output pix_x_t plot_x,
	output pix_y_t plot_y,
	output colour_t plot_colour,
	output player_t turn,
	output player_t winner
);

	col_t sel_col;
	logic drop_pulse;

	// Referee to board
	logic write_en;
	col_t write_col;
	row_t write_row;
	player_t write_player;

	board_t board;
	heights_t heights;

	c4_draw_if draw_bus ();

	////////////////////////////////////////////////////////////////////////////
	// Game core
	////////////////////////////////////////////////////////////////////////////

	c4_key_decoder i_key_decoder (
		.clk        (clk),
		.reset_n    (reset_n),
		.key_valid  (key_valid),
		.key_make   (key_make),
		.key_code   (key_code),
		.sel_col    (sel_col),
		.drop_pulse (drop_pulse)
	);

	c4_referee i_referee (
		.clk          (clk),
		.reset_n      (reset_n),
		.sel_col      (sel_col),
		.drop_pulse   (drop_pulse),
		.heights      (heights),
		.winner       (winner),
		.write_en     (write_en),
		.write_col    (write_col),
		.write_row    (write_row),
		.write_player (write_player),
		.draw         (draw_bus.requester),
		.turn         (turn)
	);

	c4_board_regs i_board_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.write_en     (write_en),
		.write_col    (write_col),
		.write_row    (write_row),
		.write_player (write_player),
		.board        (board),
		.heights      (heights)
	);

	c4_win_check i_win_check (
		.clk     (clk),
		.reset_n (reset_n),
		.board   (board),
		.winner  (winner)
	);

	// Pixel writes toward the frame buffer
	c4_piece_plotter i_piece_plotter (
		.clk         (clk),
		.reset_n     (reset_n),
		.draw        (draw_bus.plotter),
		.plot        (plot),
		.plot_x      (plot_x),
		.plot_y      (plot_y),
		.plot_colour (plot_colour)
	);

endmodule

`default_nettype wire

// ==== verification/c4_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module c4_clock_gen (
	input  logic reset_req,   // Restarts the reset window
	output logic clk,
	output logic reset_n
);

	localparam int RESET_CYCLES = 10;

	int hold;

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		hold = RESET_CYCLES;
	end

	always #10 clk = ~clk;   // 20 ns period

	always @(posedge clk) begin
		if (reset_req) begin
			hold <= RESET_CYCLES;
			reset_n <= 1'b0;
		end else if (hold != 0) begin
			hold <= hold - 1;
			reset_n <= 1'b0;
		end else begin
			reset_n <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verification/c4_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_props import c4_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic plot,
	input pix_x_t plot_x,
	input pix_y_t plot_y,
	input player_t turn,
	input player_t winner
);

	// Pixel extent of the whole board
	localparam int X_MIN = `C4_ORIGIN_X;
	localparam int X_MAX = `C4_ORIGIN_X + `C4_PITCH_X * (`C4_COLS - 1) + `C4_PIECE_SIZE - 1;
	localparam int Y_MIN = `C4_ORIGIN_Y;
	localparam int Y_MAX = `C4_ORIGIN_Y + `C4_PITCH_Y * (`C4_ROWS - 1) + `C4_PIECE_SIZE - 1;

	int assert_errors = 0;   // Read by the testbench at the end

	winner_held: assert property (@(posedge clk) disable iff (!reset_n)
		(winner != PLAYER_NONE) |=> $stable(winner))
		else begin assert_errors++; $error("winner changed after it was decided"); end

	plot_on_board: assert property (@(posedge clk) disable iff (!reset_n)
		plot |-> (plot_x >= X_MIN && plot_x <= X_MAX && plot_y >= Y_MIN && plot_y <= Y_MAX))
		else begin assert_errors++; $error("plot coordinate outside the board"); end

	// Turn flips on the accepting edge and the burst starts one edge later
	turn_before_burst: assert property (@(posedge clk) disable iff (!reset_n)
		$changed(turn) |=> $rose(plot))
		else begin assert_errors++; $error("turn changed without a following burst"); end

endmodule

`default_nettype wire

// ==== verification/c4_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module c4_tb import c4_pkg::*; ();

	localparam int BURST_TIMEOUT = 20;   // Strobe to first pixel plus margin
	localparam int QUIET_CYCLES = 48;
	localparam int RESET_TIMEOUT = 40;
	localparam scan_code_t KEY_UNKNOWN = 8'h55;

	logic clk;
	logic reset_n;
	logic reset_req;
	logic key_valid;
	logic key_make;
	scan_code_t key_code;
	logic plot;
	pix_x_t plot_x;
	pix_y_t plot_y;
	colour_t plot_colour;
	player_t turn;
	player_t winner;

	int error_count = 0;
	int check_count = 0;
	logic [7:0] lfsr_state = 8'd21;
	int col_fill [`C4_COLS];   // Expected height per column
	player_t exp_turn;
	int moves [$];

	c4_clock_gen i_clock_gen (.reset_req(reset_req), .clk(clk), .reset_n(reset_n));

	c4_top i_c4_top (
		.clk         (clk),
		.reset_n     (reset_n),
		.key_valid   (key_valid),
		.key_make    (key_make),
		.key_code    (key_code),
		.plot        (plot),
		.plot_x      (plot_x),
		.plot_y      (plot_y),
		.plot_colour (plot_colour),
		.turn        (turn),
		.winner      (winner)
	);

	bind c4_top c4_props i_c4_props (.*);

	////////////////////////////////////////////////////////////////////////////
	// Compare and report
	////////////////////////////////////////////////////////////////////////////

	task automatic note_failure(input string what);
		error_count++;
		$display("%s", what);
	endtask

	task automatic compare_player(input string name, input player_t got, input player_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_pix_x(input string name, input pix_x_t got, input pix_x_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_pix_y(input string name, input pix_y_t got, input pix_y_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_colour(input string name, input colour_t got, input colour_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic pick_column(output col_t col);
		int value;
		value = 0;
		for (int i = 0; i < 3; i++) begin
			value = (value << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		col = col_t'(value % `C4_COLS);
	endtask

	function automatic scan_code_t key_for_col(input col_t col);
		case (col)
			3'd0: return `C4_KEY_Z;
			3'd1: return `C4_KEY_X;
			3'd2: return `C4_KEY_C;
			3'd3: return `C4_KEY_V;
			3'd4: return `C4_KEY_B;
			3'd5: return `C4_KEY_N;
			default: return `C4_KEY_M;
		endcase
	endfunction

	task automatic press_key(input scan_code_t code, input logic make);
		@(posedge clk);
		key_valid <= 1'b1;
		key_make <= make;
		key_code <= code;
		@(posedge clk);
		key_valid <= 1'b0;
	endtask

	task automatic select_and_space(input col_t col);
		press_key(key_for_col(col), 1'b1);
		press_key(`C4_KEY_SPACE, 1'b1);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!reset_n && waited < RESET_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!reset_n)
			note_failure("Reset was never released");
		for (int c = 0; c < `C4_COLS; c++)
			col_fill[c] = 0;
		exp_turn = PLAYER_ONE;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		@(negedge clk);
		wait_reset_release();
	endtask

	// Waits for the burst, then checks all 36 pixels in raster order
	task automatic collect_burst(input col_t col, input colour_t colour);
		int waited;
		int row;
		pix_x_t org_x;
		pix_y_t org_y;
		row = `C4_ROWS - 1 - col_fill[col];
		org_x = pix_x_t'(`C4_ORIGIN_X + `C4_PITCH_X * col);
		org_y = pix_y_t'(`C4_ORIGIN_Y + `C4_PITCH_Y * row);
		waited = 0;
		@(negedge clk);
		while (!plot && waited < BURST_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!plot) begin
			note_failure($sformatf("No plot burst started for column %0d", col));
			return;
		end
		for (int py = 0; py < `C4_PIECE_SIZE; py++) begin
			for (int px = 0; px < `C4_PIECE_SIZE; px++) begin
				if (!plot)
					note_failure("Plot dropped inside a burst");
				compare_pix_x("plot_x", plot_x, org_x + pix_x_t'(px));
				compare_pix_y("plot_y", plot_y, org_y + pix_y_t'(py));
				compare_colour("plot_colour", plot_colour, colour);
				@(negedge clk);
			end
		end
		if (plot)
			note_failure("Burst ran past 36 pixels");
	endtask

	task automatic record_drop(input col_t col);
		col_fill[col]++;
		exp_turn = (exp_turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
		compare_player("turn", turn, exp_turn);
	endtask

	task automatic drop_piece(input col_t col);
		colour_t colour;
		colour = (exp_turn == PLAYER_ONE) ? `C4_COLOUR_P1 : `C4_COLOUR_P2;
		select_and_space(col);
		collect_burst(col, colour);
		record_drop(col);
	endtask

	task automatic expect_no_plot(input string what);
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			if (plot) begin
				note_failure($sformatf("Unexpected plot after %s", what));
				break;
			end
		end
	endtask

	task automatic play_moves();
		for (int i = 0; i < moves.size(); i++) begin
			if (i == moves.size() - 1)
				compare_player("winner", winner, PLAYER_NONE);   // No early win
			drop_piece(col_t'(moves[i]));
		end
	endtask

	task automatic check_after_win(input player_t who);
		compare_player("winner", winner, who);
		select_and_space(3'd5);
		expect_no_plot("a drop once the game is won");
		compare_player("winner", winner, who);
		compare_player("turn", turn, exp_turn);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		if (plot)
			note_failure("Plot is high after reset");
		compare_player("turn", turn, PLAYER_ONE);
		compare_player("winner", winner, PLAYER_NONE);
		press_key(`C4_KEY_SPACE, 1'b1);   // Column 0 by default
		collect_burst(3'd0, `C4_COLOUR_P1);
		record_drop(3'd0);
	endtask

	task automatic test_alternating_colours();
		col_t col;
		apply_reset();
		pick_column(col);
		drop_piece(col);   // Red on the bottom row
		drop_piece(col);   // Blue one row up
	endtask

	task automatic test_full_column();
		col_t col;
		apply_reset();
		pick_column(col);
		for (int i = 0; i < `C4_ROWS; i++)
			drop_piece(col);
		press_key(`C4_KEY_SPACE, 1'b1);
		expect_no_plot("a drop into a full column");
		compare_player("turn", turn, exp_turn);
	endtask

	task automatic test_wins();
		apply_reset();
		moves = '{0, 1, 0, 1, 0, 1, 0};   // Vertical in column 0
		play_moves();
		check_after_win(PLAYER_ONE);
		apply_reset();
		moves = '{0, 1, 0, 2, 0, 3, 6, 4};   // Bottom row from column 1 to 4
		play_moves();
		check_after_win(PLAYER_TWO);
		apply_reset();
		moves = '{0, 1, 1, 2, 2, 3, 2, 3, 3, 6, 3};   // Rising diagonal
		play_moves();
		check_after_win(PLAYER_ONE);
	endtask

	task automatic test_refusals();
		apply_reset();
		select_and_space(3'd3);
		fork
			collect_burst(3'd3, `C4_COLOUR_P1);
			begin
				repeat (10) @(posedge clk);
				press_key(`C4_KEY_SPACE, 1'b1);   // Lands mid burst
			end
		join
		record_drop(3'd3);
		expect_no_plot("SPACE during a burst");
		press_key(`C4_KEY_M, 1'b0);
		press_key(KEY_UNKNOWN, 1'b1);
		press_key(`C4_KEY_SPACE, 1'b0);
		expect_no_plot("releases and unknown codes");
		compare_player("turn", turn, exp_turn);
		press_key(`C4_KEY_SPACE, 1'b1);   // Column 3 still selected
		collect_burst(3'd3, `C4_COLOUR_P2);
		record_drop(3'd3);
	endtask

	initial begin
		reset_req = 1'b0;
		key_valid = 1'b0;
		key_make = 1'b0;
		key_code = '0;
		wait_reset_release();
		test_reset_state();
		test_alternating_colours();
		test_full_column();
		test_wins();
		test_refusals();
		error_count += i_c4_top.i_c4_props.assert_errors;
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/c4_pkg.sv
src/c4_draw_if.sv
src/c4_key_decoder.sv
src/c4_board_regs.sv
src/c4_referee.sv
src/c4_win_check.sv
src/c4_piece_plotter.sv
src/c4_top.sv
verification/c4_clock_gen.sv
verification/c4_props.sv
verification/c4_tb.sv
